// File: logic/fc_pkg.sv
package fc_pkg;

    // Int8 values per memory word
    localparam int LANES = 4;

    // Arithmetic shift after the bias add
    localparam int ACC_SHIFT = 4;

    typedef logic signed [7:0] lane_t;

    // Lane 0 in the low byte holds the lowest element index
    typedef lane_t [LANES-1:0] word_t;

    typedef logic signed [23:0] acc_t;

    // Host load, sel picks the activation (0) or parameter (1) memory
    typedef struct packed {
        logic       en;
        logic       sel;
        logic [7:0] addr;
        word_t      data;
    } host_wr_t;

    // Travels with each read and arrives together with the read data
    typedef struct packed {
        logic       valid;
        logic       is_bias;
        logic [1:0] lane;
        logic       final_layer;
        logic [7:0] index;
        logic       last;
    } mac_tag_t;

    // One finished output-layer neuron
    typedef struct packed {
        logic       valid;
        logic [7:0] index;
        lane_t      value;
        logic       last;
    } score_t;

    // Hidden word written back into activation memory
    typedef struct packed {
        logic       en;
        logic [7:0] addr;
        word_t      data;
    } act_wr_t;

endpackage

// File: logic/word_ram.sv
`timescale 1ns/100ps

module word_ram #(
    parameter int AW = 4
) (
    input  logic            clk,
    input  logic            we,
    input  logic [AW-1:0]   waddr,
    input  fc_pkg::word_t   wdata,
    input  logic [AW-1:0]   raddr,
    output fc_pkg::word_t   rdata
);

    fc_pkg::word_t mem [2**AW];

    // One write port, read data registered with one cycle of latency
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

// File: logic/layer_sequencer.sv
`timescale 1ns/100ps

module layer_sequencer #(
    parameter int N_IN     = 16,
    parameter int N_HID    = 8,
    parameter int N_OUT    = 10,
    parameter int ACT_AW   = 4,
    parameter int PARAM_AW = 6
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                start,
    output logic [ACT_AW-1:0]   act_raddr,
    output logic [PARAM_AW-1:0] param_raddr,
    output fc_pkg::mac_tag_t    tag,
    output logic                busy
);

    // Words per neuron row in each layer
    localparam logic [7:0] IN_W  = 8'(N_IN / fc_pkg::LANES);
    localparam logic [7:0] HID_W = 8'(N_HID / fc_pkg::LANES);

    localparam logic [7:0] LAST_HID = 8'(N_HID - 1);
    localparam logic [7:0] LAST_OUT = 8'(N_OUT - 1);

    // Memory bases, all derived from the layer sizes
    localparam logic [ACT_AW-1:0]   HID_BASE = ACT_AW'(N_IN / fc_pkg::LANES);
    localparam logic [PARAM_AW-1:0] B0_BASE  = PARAM_AW'(N_HID * N_IN / fc_pkg::LANES);
    localparam logic [PARAM_AW-1:0] W1_BASE  =
        PARAM_AW'(N_HID * N_IN / fc_pkg::LANES + N_HID / fc_pkg::LANES);
    localparam logic [PARAM_AW-1:0] B1_BASE  =
        W1_BASE + PARAM_AW'(N_OUT * N_HID / fc_pkg::LANES);

    // Lets the last hidden write land before layer 1 reads it
    localparam logic [1:0] DRAIN_LAST = 2'd2;

    typedef enum logic [1:0] {
        S_IDLE,
        S_L0,
        S_DRAIN,
        S_L1
    } state_t;

    state_t                state;
    logic [7:0]            neuron;
    logic [7:0]            word;
    logic [PARAM_AW-1:0]   w_ptr;
    logic [1:0]            drain_cnt;
    logic                  l1_done;

    logic                  l1;
    logic                  issue;
    logic                  bias_rd;
    logic [7:0]            words_per;
    logic [7:0]            last_neuron;
    fc_pkg::mac_tag_t      tag_next;

    always_comb begin
        l1          = state == S_L1;
        issue       = (state == S_L0) || l1;
        words_per   = l1 ? HID_W : IN_W;
        last_neuron = l1 ? LAST_OUT : LAST_HID;
        // Bias read follows the last dot-product word of a neuron
        bias_rd     = word == words_per;

        act_raddr = (l1 ? HID_BASE : '0) + word[ACT_AW-1:0];
        if (bias_rd) begin
            param_raddr = (l1 ? B1_BASE : B0_BASE) + PARAM_AW'(neuron[7:2]);
        end else begin
            param_raddr = w_ptr;
        end

        tag_next.valid       = issue;
        tag_next.is_bias     = bias_rd;
        tag_next.lane        = neuron[1:0];
        tag_next.final_layer = l1;
        tag_next.index       = neuron;
        tag_next.last        = neuron == last_neuron;
    end

    assign busy = state != S_IDLE;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= S_IDLE;
            neuron    <= '0;
            word      <= '0;
            w_ptr     <= '0;
            drain_cnt <= '0;
            l1_done   <= 1'b0;
            tag       <= '0;
        end else begin
            // Same delay as the RAM read data
            tag <= tag_next;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= S_L0;
                        neuron  <= '0;
                        word    <= '0;
                        w_ptr   <= '0;
                        l1_done <= 1'b0;
                    end
                end
                S_L0, S_L1: begin
                    if (bias_rd) begin
                        word <= '0;
                        if (neuron == last_neuron) begin
                            neuron    <= '0;
                            drain_cnt <= '0;
                            l1_done   <= l1;
                            w_ptr     <= W1_BASE;
                            state     <= S_DRAIN;
                        end else begin
                            neuron <= neuron + 8'd1;
                        end
                    end else begin
                        // Weight rows of a layer sit back to back
                        word  <= word + 8'd1;
                        w_ptr <= w_ptr + 1'b1;
                    end
                end
                S_DRAIN: begin
                    drain_cnt <= drain_cnt + 2'd1;
                    // After the output layer, idle on the edge t_valid rises
                    if (l1_done && drain_cnt == DRAIN_LAST - 2'd1) begin
                        state <= S_IDLE;
                    end else if (drain_cnt == DRAIN_LAST) begin
                        state <= S_L1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/neuron_engine.sv
`timescale 1ns/100ps

module neuron_engine #(
    parameter int N_IN = 16
) (
    input  logic              clk,
    input  logic              rstn,
    input  fc_pkg::word_t     act_word,
    input  fc_pkg::word_t     param_word,
    input  fc_pkg::mac_tag_t  tag,
    output fc_pkg::act_wr_t   act_wr,
    output fc_pkg::score_t    score
);

    // Hidden vector follows the input vector in activation memory
    localparam logic [7:0] HID_BASE = 8'(N_IN / fc_pkg::LANES);

    fc_pkg::acc_t  acc;
    fc_pkg::acc_t  dot;
    fc_pkg::acc_t  sum;
    fc_pkg::acc_t  shifted;
    fc_pkg::acc_t  clamped;
    fc_pkg::lane_t result;
    fc_pkg::word_t pack;
    fc_pkg::word_t pack_next;

    always_comb begin
        // Four-lane dot product of one word pair
        dot = '0;
        for (int i = 0; i < fc_pkg::LANES; i++) begin
            dot = dot + fc_pkg::acc_t'(act_word[i] * param_word[i]);
        end

        sum     = acc + fc_pkg::acc_t'(param_word[tag.lane]);
        shifted = sum >>> fc_pkg::ACC_SHIFT;

        // ReLU on the hidden layer only
        if (!tag.final_layer && shifted < 0) begin
            clamped = '0;
        end else begin
            clamped = shifted;
        end

        if (clamped > 127) begin
            result = 8'sh7f;
        end else if (clamped < -128) begin
            result = 8'sh80;
        end else begin
            result = clamped[7:0];
        end

        pack_next           = pack;
        pack_next[tag.lane] = result;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc    <= '0;
            act_wr <= '0;
            score  <= '0;
        end else begin
            act_wr.en   <= 1'b0;
            score.valid <= 1'b0;
            if (tag.valid) begin
                if (tag.is_bias) begin
                    // Neuron done, accumulator ready for the next one
                    acc <= '0;
                    if (tag.final_layer) begin
                        score.valid <= 1'b1;
                        score.index <= tag.index;
                        score.value <= result;
                        score.last  <= tag.last;
                    end else if (tag.lane == 2'd3) begin
                        act_wr.en   <= 1'b1;
                        act_wr.addr <= HID_BASE + {2'b00, tag.index[7:2]};
                        act_wr.data <= pack_next;
                    end
                end else begin
                    acc <= acc + dot;
                end
            end
        end
    end

    // Hidden results collect four to a word
    always_ff @(posedge clk) begin
        if (tag.valid && tag.is_bias && !tag.final_layer) begin
            pack <= pack_next;
        end
    end

endmodule

// File: logic/argmax_unit.sv
`timescale 1ns/100ps

module argmax_unit (
    input  logic            clk,
    input  logic            rstn,
    input  logic            start,
    input  fc_pkg::score_t  score,
    output logic            t_valid,
    output logic [3:0]      class_idx
);

    logic          run;
    logic          seen;
    logic          take;
    fc_pkg::lane_t max_val;

    // Strictly greater only, so ties keep the lowest index
    assign take = score.valid && (!seen || score.value > max_val);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            t_valid   <= 1'b0;
            class_idx <= '0;
            run       <= 1'b0;
            seen      <= 1'b0;
        end else begin
            // Outside a run means idle or a result is already shown
            if (start && !run) begin
                t_valid <= 1'b0;
                run     <= 1'b1;
                seen    <= 1'b0;
            end
            if (score.valid) begin
                seen <= 1'b1;
                if (take) begin
                    class_idx <= score.index[3:0];
                end
                if (score.last) begin
                    t_valid <= 1'b1;
                    run     <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            max_val <= score.value;
        end
    end

endmodule

// File: logic/fc_top.sv
`timescale 1ns/100ps

module fc_top #(
    parameter int N_IN     = 16,
    parameter int N_HID    = 8,
    parameter int N_OUT    = 10,
    parameter int ACT_AW   = 4,
    parameter int PARAM_AW = 6
) (
    input  logic             clk,
    input  logic             rstn,
    input  fc_pkg::host_wr_t host,
    input  logic             start,
    output logic             t_valid,
    output logic [3:0]       class_idx
);

    logic                  busy;
    logic                  host_act_we;
    logic                  host_param_we;

    logic                  act_we;
    logic [ACT_AW-1:0]     act_waddr;
    fc_pkg::word_t         act_wdata;

    logic [ACT_AW-1:0]     act_raddr;
    logic [PARAM_AW-1:0]   param_raddr;
    fc_pkg::word_t         act_rdata;
    fc_pkg::word_t         param_rdata;

    fc_pkg::mac_tag_t      tag;
    fc_pkg::act_wr_t       act_wr;
    fc_pkg::score_t        score;

    // Host loads only while the engine is idle
    assign host_act_we   = host.en && !busy && !host.sel;
    assign host_param_we = host.en && !busy && host.sel;

    // Hidden write-back takes the activation port during a run
    assign act_we    = act_wr.en || host_act_we;
    assign act_waddr = act_wr.en ? act_wr.addr[ACT_AW-1:0] : host.addr[ACT_AW-1:0];
    assign act_wdata = act_wr.en ? act_wr.data : host.data;

    word_ram #(
        .AW (ACT_AW)
    ) i_act_ram (
        .clk   (clk),
        .we    (act_we),
        .waddr (act_waddr),
        .wdata (act_wdata),
        .raddr (act_raddr),
        .rdata (act_rdata)
    );

    word_ram #(
        .AW (PARAM_AW)
    ) i_param_ram (
        .clk   (clk),
        .we    (host_param_we),
        .waddr (host.addr[PARAM_AW-1:0]),
        .wdata (host.data),
        .raddr (param_raddr),
        .rdata (param_rdata)
    );

    layer_sequencer #(
        .N_IN     (N_IN),
        .N_HID    (N_HID),
        .N_OUT    (N_OUT),
        .ACT_AW   (ACT_AW),
        .PARAM_AW (PARAM_AW)
    ) i_seq (
        .clk         (clk),
        .rstn        (rstn),
        .start       (start),
        .act_raddr   (act_raddr),
        .param_raddr (param_raddr),
        .tag         (tag),
        .busy        (busy)
    );

    neuron_engine #(
        .N_IN (N_IN)
    ) i_engine (
        .clk        (clk),
        .rstn       (rstn),
        .act_word   (act_rdata),
        .param_word (param_rdata),
        .tag        (tag),
        .act_wr     (act_wr),
        .score      (score)
    );

    argmax_unit i_argmax (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .score     (score),
        .t_valid   (t_valid),
        .class_idx (class_idx)
    );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

// File: verif/fc_tb.sv
`timescale 1ns/100ps

module fc_tb;

    localparam int N_IN     = 16;
    localparam int N_HID    = 8;
    localparam int N_OUT    = 10;
    localparam int ACT_AW   = 4;
    localparam int PARAM_AW = 6;

    // Memory layout, words per row and region bases
    localparam int IN_W    = N_IN / 4;
    localparam int HID_W   = N_HID / 4;
    localparam int OUT_W   = (N_OUT + 3) / 4;
    localparam int B0_BASE = N_HID * IN_W;
    localparam int W1_BASE = B0_BASE + HID_W;
    localparam int B1_BASE = W1_BASE + N_OUT * HID_W;

    // Start pulse to t_valid, both layers of reads plus drain and result stages
    localparam int RUN_CYCLES = N_HID * (IN_W + 1) + 3 + N_OUT * (HID_W + 1) + 3;

    localparam int SEED           = 85335;
    localparam int RANDOM_RUNS    = 40;
    localparam int TOTAL_RUNS     = RANDOM_RUNS + 3;
    localparam int TIMEOUT_CYCLES = TOTAL_RUNS * 120 + 200;

    logic             clk;
    logic             rstn;
    fc_pkg::host_wr_t host;
    logic             start;
    logic             t_valid;
    logic [3:0]       class_idx;

    // Model copy of the network
    int img [N_IN];
    int w0 [N_HID][N_IN];
    int b0 [N_HID];
    int w1 [N_OUT][N_HID];
    int b1 [N_OUT];

    int errors;
    int checks;
    int cycle_count;
    int last_class;
    bit result_shown;

    tb_clock #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (10)
    ) i_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    fc_top #(
        .N_IN     (N_IN),
        .N_HID    (N_HID),
        .N_OUT    (N_OUT),
        .ACT_AW   (ACT_AW),
        .PARAM_AW (PARAM_AW)
    ) i_dut (
        .clk       (clk),
        .rstn      (rstn),
        .host      (host),
        .start     (start),
        .t_valid   (t_valid),
        .class_idx (class_idx)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("MISMATCH at %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Uniform in -lim .. lim-1
    function automatic int rand_value(input int lim);
        return int'($urandom_range(2 * lim - 1)) - lim;
    endfunction

    function automatic int saturate(input int v);
        if (v > 127) begin
            return 127;
        end
        if (v < -128) begin
            return -128;
        end
        return v;
    endfunction

    function automatic int model_class();
        int hid [N_HID];
        int acc;
        int score;
        int best;
        int best_idx;
        for (int h = 0; h < N_HID; h++) begin
            acc = b0[h];
            for (int i = 0; i < N_IN; i++) begin
                acc += img[i] * w0[h][i];
            end
            acc = acc >>> 4;
            // ReLU on the hidden layer
            if (acc < 0) begin
                acc = 0;
            end
            hid[h] = saturate(acc);
        end
        best     = 0;
        best_idx = 0;
        for (int o = 0; o < N_OUT; o++) begin
            acc = b1[o];
            for (int j = 0; j < N_HID; j++) begin
                acc += hid[j] * w1[o][j];
            end
            score = saturate(acc >>> 4);
            // Ties stay with the lowest index
            if (o == 0 || score > best) begin
                best     = score;
                best_idx = o;
            end
        end
        return best_idx;
    endfunction

    function automatic fc_pkg::word_t pack_lanes(input int a, input int b,
                                                 input int c, input int d);
        fc_pkg::word_t w;
        w[0] = a[7:0];
        w[1] = b[7:0];
        w[2] = c[7:0];
        w[3] = d[7:0];
        return w;
    endfunction

    task automatic host_write(input logic sel, input int addr, input fc_pkg::word_t data);
        @(negedge clk);
        host.en   = 1'b1;
        host.sel  = sel;
        host.addr = addr[7:0];
        host.data = data;
    endtask

    task automatic host_release();
        @(negedge clk);
        host = '0;
    endtask

    task automatic load_image();
        for (int w = 0; w < IN_W; w++) begin
            host_write(1'b0, w, pack_lanes(img[4*w], img[4*w+1], img[4*w+2], img[4*w+3]));
        end
        host_release();
    endtask

    task automatic load_params();
        int v [4];
        for (int h = 0; h < N_HID; h++) begin
            for (int w = 0; w < IN_W; w++) begin
                host_write(1'b1, h * IN_W + w, pack_lanes(w0[h][4*w], w0[h][4*w+1],
                                                          w0[h][4*w+2], w0[h][4*w+3]));
            end
        end
        for (int w = 0; w < HID_W; w++) begin
            host_write(1'b1, B0_BASE + w, pack_lanes(b0[4*w], b0[4*w+1], b0[4*w+2], b0[4*w+3]));
        end
        for (int o = 0; o < N_OUT; o++) begin
            for (int w = 0; w < HID_W; w++) begin
                host_write(1'b1, W1_BASE + o * HID_W + w,
                           pack_lanes(w1[o][4*w], w1[o][4*w+1], w1[o][4*w+2], w1[o][4*w+3]));
            end
        end
        // Last bias word may be partly unused
        for (int w = 0; w < OUT_W; w++) begin
            for (int k = 0; k < 4; k++) begin
                v[k] = (4 * w + k < N_OUT) ? b1[4*w+k] : 0;
            end
            host_write(1'b1, B1_BASE + w, pack_lanes(v[0], v[1], v[2], v[3]));
        end
        host_release();
    endtask

    task automatic randomize_image(input int lim);
        for (int i = 0; i < N_IN; i++) begin
            img[i] = rand_value(lim);
        end
    endtask

    task automatic randomize_params(input int wlim);
        for (int h = 0; h < N_HID; h++) begin
            b0[h] = rand_value(128);
            for (int i = 0; i < N_IN; i++) begin
                w0[h][i] = rand_value(wlim);
            end
        end
        for (int o = 0; o < N_OUT; o++) begin
            b1[o] = rand_value(128);
            for (int j = 0; j < N_HID; j++) begin
                w1[o][j] = rand_value(wlim);
            end
        end
    endtask

    task automatic hold_check(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("t_valid", 1, t_valid);
            check_value("class_idx", last_class, class_idx);
        end
    endtask

    // Start pulse, optional second pulse mid-run, then wait for the result
    task automatic run_and_check(input int expected, input int mid_start);
        int latency;
        if (result_shown) begin
            check_value("t_valid", 1, t_valid);
            check_value("class_idx", last_class, class_idx);
        end
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        latency = 1;
        check_value("t_valid", 0, t_valid);
        if (mid_start > 0) begin
            repeat (mid_start) @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            latency += mid_start + 1;
        end
        while (t_valid !== 1'b1) begin
            @(negedge clk);
            latency++;
        end
        // A restarted run would show a longer latency
        check_value("t_valid latency", RUN_CYCLES, latency);
        check_value("class_idx", expected, class_idx);
        last_class   = expected;
        result_shown = 1'b1;
        // A long hold shows that t_valid rose only once
        hold_check(mid_start > 0 ? 90 : 4);
    endtask

    // All hidden values end up zero, class set by one large output bias
    task automatic relu_case();
        int top;
        randomize_image(8);
        randomize_params(1);
        for (int h = 0; h < N_HID; h++) begin
            b0[h] = -128;
        end
        for (int o = 0; o < N_OUT; o++) begin
            b1[o] = rand_value(64);
        end
        top     = $urandom_range(N_OUT - 1);
        b1[top] = 120;
        load_image();
        load_params();
        run_and_check(top, 0);
    endtask

    // Three outputs saturate at 127, the lowest of them wins
    task automatic saturation_case();
        int low;
        randomize_image(128);
        for (int h = 0; h < N_HID; h++) begin
            b0[h] = 127;
            for (int i = 0; i < N_IN; i++) begin
                w0[h][i] = 0;
            end
        end
        for (int o = 0; o < N_OUT; o++) begin
            b1[o] = rand_value(128);
            for (int j = 0; j < N_HID; j++) begin
                w1[o][j] = rand_value(8);
            end
        end
        low = $urandom_range(7);
        for (int j = 0; j < N_HID; j++) begin
            w1[low][j]       = 127;
            w1[low+2][j]     = 127;
            w1[N_OUT-1][j]   = 127;
        end
        load_image();
        load_params();
        run_and_check(low, 0);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        host         = '0;
        start        = 1'b0;
        errors       = 0;
        checks       = 0;
        last_class   = 0;
        result_shown = 1'b0;

        wait (rstn === 1'b1);
        @(negedge clk);
        check_value("t_valid", 0, t_valid);
        check_value("class_idx", 0, class_idx);

        // Weights change every fourth run
        for (int run = 0; run < RANDOM_RUNS; run++) begin
            randomize_image(128);
            load_image();
            if (run % 4 == 0) begin
                randomize_params((run % 8 == 0) ? 8 : 32);
                load_params();
            end
            run_and_check(model_class(), 0);
        end

        relu_case();
        saturation_case();

        randomize_image(128);
        randomize_params(8);
        load_image();
        load_params();
        run_and_check(model_class(), 20);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: list.f
logic/fc_pkg.sv
logic/word_ram.sv
logic/layer_sequencer.sv
logic/neuron_engine.sv
logic/argmax_unit.sv
logic/fc_top.sv
verif/tb_clock.sv
verif/fc_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP      = fc_tb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "TEST FAILED"; exit 1)
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD) $(LOG)
